// File: l1d_cache.f
verilog/l1d_pkg.sv
verilog/l1d_line_store.sv
verilog/l1d_align.sv
verilog/l1d_mem_port.sv
verilog/l1d_ctrl.sv
verilog/l1d_cache.sv
verif/l1d_cache_tb.sv

// File: run.sh
#!/bin/sh
# build and run the cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module l1d_cache_tb \
    -f l1d_cache.f -o l1d_cache_sim --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/l1d_cache_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Finished with no errors"; then
    exit 0
fi
exit 1

// File: verif/l1d_cache_tb.sv
`timescale 1ns/1ps

module l1d_cache_tb;
    import l1d_pkg::*;

    localparam int NUM_RANDOM = 96;
    // directed part is about 30 accesses, each well under 40 cycles
    localparam int MAX_CYCLES = (NUM_RANDOM + 30) * 40 + 1000;

    typedef struct packed {
        logic        we;
        logic [31:0] adr;
    } beat_t;

    typedef struct packed {
        logic [63:0] data;
        logic [3:0]  rob;
    } load_exp_t;

    logic        clk;
    logic        rstn;
    logic        req_valid;
    cache_req_t  req;
    logic        req_ready;
    logic        resp_valid;
    cache_resp_t resp;
    logic        resp_credit;
    mem_req_t    mem_req;
    mem_rsp_t    mem_rsp;

    integer      seed;
    int          cycle_cnt;
    int          outstanding;
    int          beat_wait;
    int          credit_delay;
    int          ack_delay;
    logic        seen_req;
    logic        hold_credits;
    logic [3:0]  rob_next;
    logic [255:0]       ref_valid;
    logic [255:0]       ref_dirty;
    logic [20:0]        ref_tag [256];
    logic [7:0]         shadow [logic [31:0]];
    logic [31:0]        mem_words [logic [31:0]];
    beat_t              exp_beats [$];
    load_exp_t          exp_loads [$];
    int                 credit_due [$];

    l1d_cache dut_i (
        .clk           (clk),
        .rstn          (rstn),
        .req_valid_i   (req_valid),
        .req_i         (req),
        .req_ready_o   (req_ready),
        .resp_valid_o  (resp_valid),
        .resp_o        (resp),
        .resp_credit_i (resp_credit),
        .mem_req_o     (mem_req),
        .mem_rsp_i     (mem_rsp)
    );

    always #20 clk = ~clk;

    ////////////////////
    // error reporting

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic value_error(string name, logic [63:0] exp, logic [63:0] act);
        $display("ERROR at %0t ns: %s expected 0x%h, actual 0x%h", $time, name, exp, act);
        abort_run();
    endtask

    task automatic report_failure(string msg);
        $display("at %0t ns: %s", $time, msg);
        abort_run();
    endtask

    ////////////////////
    // reference model

    function automatic logic [31:0] init_word(logic [31:0] a);
        return {a[31:2], 2'b00} ^ 32'h5a5a_0000;
    endfunction

    function automatic logic [7:0] shadow_byte(logic [31:0] a);
        logic [31:0] w;
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        w = init_word(a);
        return w[8*a[1:0] +: 8];
    endfunction

    function automatic logic [63:0] expect_load(access_size_e size, logic [31:0] a);
        logic [63:0] v;
        int          n;
        v = '0;
        n = 1 << (int'(size) & 3);
        for (int i = 0; i < n; i++) begin
            v[8*i +: 8] = shadow_byte(a + 32'(i));
        end
        // sizes below 4 are signed
        if (!size[2] && n < 8 && v[8*n-1]) begin
            v = v | ~((64'd1 << (8*n)) - 64'd1);
        end
        return v;
    endfunction

    task automatic record_accept(cache_req_t r);
        logic [7:0]  idx;
        logic [20:0] tag;
        int          n;
        idx = r.addr[10:3];
        tag = r.addr[31:11];
        n   = 1 << (int'(r.size) & 3);
        assert (exp_beats.size() == 0)
            else report_failure("previous miss left bus beats unserved");
        if (!(ref_valid[idx] && ref_tag[idx] == tag)) begin
            // dirty victim goes out before the refill
            if (ref_valid[idx] && ref_dirty[idx]) begin
                exp_beats.push_back({1'b1, ref_tag[idx], idx, 3'b000});
                exp_beats.push_back({1'b1, ref_tag[idx], idx, 3'b100});
            end
            exp_beats.push_back({1'b0, tag, idx, 3'b000});
            exp_beats.push_back({1'b0, tag, idx, 3'b100});
            ref_valid[idx] = 1'b1;
            ref_dirty[idx] = 1'b0;
            ref_tag[idx]   = tag;
        end
        if (r.op == MEM_STORE) begin
            ref_dirty[idx] = 1'b1;
            for (int i = 0; i < n; i++) begin
                shadow[r.addr + 32'(i)] = r.wdata[8*i +: 8];
            end
        end else begin
            exp_loads.push_back({expect_load(r.size, r.addr), r.rob_idx});
        end
    endtask

    ////////////////////
    // memory model and credit return

    task automatic serve_beat();
        beat_t       b;
        logic [31:0] w;
        if (exp_beats.size() == 0) begin
            report_failure("memory bus cycle during an access that should hit");
        end else begin
            b = exp_beats.pop_front();
            assert (mem_req.we == b.we)
                else value_error("mem_req_o.we", 64'(b.we), 64'(mem_req.we));
            assert (mem_req.adr == b.adr)
                else value_error("mem_req_o.adr", 64'(b.adr), 64'(mem_req.adr));
            if (mem_req.we) begin
                for (int i = 0; i < 4; i++) begin
                    w[8*i +: 8] = shadow_byte(b.adr + 32'(i));
                end
                assert (mem_req.dat == w)
                    else value_error("mem_req_o.dat", 64'(w), 64'(mem_req.dat));
                mem_words[mem_req.adr] = mem_req.dat;
            end else if (mem_words.exists(mem_req.adr)) begin
                mem_rsp.rdata = mem_words[mem_req.adr];
            end else begin
                mem_rsp.rdata = init_word(mem_req.adr);
            end
        end
    endtask

    always @(posedge clk) begin : env_model
        credit_delay = $unsigned($random(seed)) % 5;
        ack_delay    = $unsigned($random(seed)) % 3;
        if (!rstn && resp_valid) begin
            credit_due.push_back(cycle_cnt + credit_delay);
        end
        #2;
        resp_credit = 1'b0;
        if (!hold_credits && credit_due.size() > 0 && credit_due[0] <= cycle_cnt) begin
            void'(credit_due.pop_front());
            resp_credit = 1'b1;
        end
        mem_rsp.ack = 1'b0;
        if (!rstn && mem_req.cyc) begin
            if (beat_wait < 0) begin
                beat_wait = ack_delay;
            end
            if (beat_wait == 0) begin
                serve_beat();
                mem_rsp.ack = 1'b1;
                beat_wait   = -1;
            end else begin
                beat_wait = beat_wait - 1;
            end
        end
    end

    always @(posedge clk) begin : check_response
        load_exp_t e;
        if (!rstn && resp_valid) begin
            if (exp_loads.size() == 0) begin
                report_failure("load response with no load outstanding");
            end else begin
                e = exp_loads.pop_front();
                assert (resp.ld_data == e.data)
                    else value_error("resp_o.ld_data", e.data, resp.ld_data);
                assert (resp.rob_idx == e.rob)
                    else value_error("resp_o.rob_idx", 64'(e.rob), 64'(resp.rob_idx));
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (!rstn) begin
            outstanding <= outstanding + int'(resp_valid) - int'(resp_credit);
        end
        if (cycle_cnt >= MAX_CYCLES) begin
            report_failure("timeout, the run did not finish in time");
        end
    end

    quiet_after_reset_a: assert property (@(posedge clk) disable iff (rstn)
        !seen_req |-> req_ready && !resp_valid && !mem_req.cyc)
        else report_failure("cache not idle after reset");

    credit_limit_a: assert property (@(posedge clk) disable iff (rstn)
        outstanding <= RESP_CREDITS)
        else report_failure("more responses than credits");

    no_accept_without_credit_a: assert property (@(posedge clk) disable iff (rstn)
        outstanding == RESP_CREDITS |-> !req_ready)
        else report_failure("request accepted with no credit left");

    ////////////////////
    // stimulus

    task automatic issue(mem_op_e op, access_size_e size, logic [31:0] addr, logic [63:0] wdata);
        cache_req_t r;
        r.op      = op;
        r.size    = size;
        r.addr    = addr;
        r.wdata   = wdata;
        r.rob_idx = rob_next;
        req       = r;
        req_valid = 1'b1;
        seen_req  = 1'b1;
        @(posedge clk);
        while (!req_ready) begin
            @(posedge clk);
        end
        record_accept(r);
        #2;
        req_valid = 1'b0;
        rob_next  = rob_next + 4'd1;
    endtask

    function automatic logic [31:0] make_addr(int tag, int idx, access_size_e size, int off);
        int n;
        n = 1 << (int'(size) & 3);
        return 32'(tag << 11) | 32'(idx << 3) | 32'(off & 7 & ~(n - 1));
    endfunction

    initial begin
        access_size_e sz;
        logic [63:0]  wd;
        clk = 1'b0;
        rstn = 1'b1;
        req_valid = 1'b0;
        req = '0;
        resp_credit = 1'b0;
        mem_rsp = '0;
        seed = 32'h8db713eb;
        cycle_cnt = 0;
        outstanding = 0;
        beat_wait = -1;
        seen_req = 1'b0;
        hold_credits = 1'b0;
        rob_next = '0;
        ref_valid = '0;
        ref_dirty = '0;
        repeat (4) @(posedge clk);
        #2;
        rstn = 1'b0;
        repeat (3) @(posedge clk);
        #2;

        // every size stored, then read back wide and narrow
        for (int s = 0; s < 7; s++) begin
            sz = access_size_e'(s);
            wd = {$random(seed), $random(seed)};
            issue(MEM_STORE, sz, make_addr(1, s + 1, sz, s * 3), wd);
            issue(MEM_LOAD, SZ_D, make_addr(1, s + 1, SZ_D, 0), '0);
            issue(MEM_LOAD, sz, make_addr(1, s + 1, sz, s * 3), '0);
        end

        // conflict on index 1 evicts the dirty line, then brings it back
        issue(MEM_LOAD, SZ_W, make_addr(2, 1, SZ_W, 4), '0);
        issue(MEM_LOAD, SZ_D, make_addr(1, 1, SZ_D, 0), '0);
        issue(MEM_LOAD, SZ_HU, make_addr(2, 1, SZ_HU, 6), '0);

        // consumer withholds credits once the last miss is answered
        while (outstanding != 0 || !req_ready) begin
            @(posedge clk);
        end
        #2;
        hold_credits = 1'b1;
        issue(MEM_LOAD, SZ_B, make_addr(1, 2, SZ_B, 1), '0);
        issue(MEM_LOAD, SZ_WU, make_addr(1, 3, SZ_WU, 4), '0);
        fork
            begin
                repeat (12) @(posedge clk);
                hold_credits = 1'b0;
            end
        join_none
        issue(MEM_LOAD, SZ_H, make_addr(1, 4, SZ_H, 2), '0);
        assert (!hold_credits) else report_failure("request accepted while credits were withheld");

        for (int k = 0; k < NUM_RANDOM; k++) begin
            sz = access_size_e'($unsigned($random(seed)) % 7);
            wd = {$random(seed), $random(seed)};
            issue(($random(seed) & 1) ? MEM_STORE : MEM_LOAD, sz,
                  make_addr($unsigned($random(seed)) % 4, $unsigned($random(seed)) % 8,
                            sz, $unsigned($random(seed)) % 8), wd);
        end

        while (exp_loads.size() != 0 || !req_ready) begin
            @(posedge clk);
        end
        if (exp_beats.size() != 0) begin
            report_failure("expected memory beats never happened");
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

// File: verilog/l1d_align.sv
`timescale 1ns/1ps

module l1d_align (
    input  l1d_pkg::cache_req_t                 req_i,
    input  logic [l1d_pkg::XLEN-1:0]            line_i,
    output logic [l1d_pkg::XLEN-1:0]            ld_data_o,
    output logic [l1d_pkg::XLEN-1:0]            merged_line_o,
    output logic [l1d_pkg::BYTES_PER_LINE-1:0]  store_mask_o
);
    import l1d_pkg::*;

    logic [OFFSET_W-1:0]        offset;
    logic [XLEN-1:0]            shifted;
    logic [XLEN-1:0]            wdata_sh;
    logic [BYTES_PER_LINE-1:0]  lanes;

    assign offset   = req_i.addr[OFFSET_W-1:0];
    assign shifted  = line_i >> {offset, 3'b000};
    assign wdata_sh = req_i.wdata << {offset, 3'b000};

    ////////////////////
    // load extraction

    always_comb begin
        case (req_i.size)
            SZ_B:    ld_data_o = {{(XLEN-8){shifted[7]}}, shifted[7:0]};
            SZ_H:    ld_data_o = {{(XLEN-16){shifted[15]}}, shifted[15:0]};
            SZ_W:    ld_data_o = {{(XLEN-32){shifted[31]}}, shifted[31:0]};
            SZ_BU:   ld_data_o = {{(XLEN-8){1'b0}}, shifted[7:0]};
            SZ_HU:   ld_data_o = {{(XLEN-16){1'b0}}, shifted[15:0]};
            SZ_WU:   ld_data_o = {{(XLEN-32){1'b0}}, shifted[31:0]};
            default: ld_data_o = shifted;
        endcase
    end

    ////////////////////
    // store merge

    always_comb begin
        case (req_i.size)
            SZ_B, SZ_BU: lanes = 8'h01;
            SZ_H, SZ_HU: lanes = 8'h03;
            SZ_W, SZ_WU: lanes = 8'h0f;
            default:     lanes = 8'hff;
        endcase
    end

    // loads leave the line untouched
    assign store_mask_o = (req_i.op == MEM_STORE) ? (lanes << offset) : '0;

    always_comb begin
        for (int b = 0; b < BYTES_PER_LINE; b++) begin
            merged_line_o[8*b +: 8] = store_mask_o[b] ? wdata_sh[8*b +: 8] : line_i[8*b +: 8];
        end
    end

endmodule

// File: verilog/l1d_cache.sv
`timescale 1ns/1ps

module l1d_cache (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  req_valid_i,
    input  l1d_pkg::cache_req_t   req_i,
    output logic                  req_ready_o,
    output logic                  resp_valid_o,
    output l1d_pkg::cache_resp_t  resp_o,
    input  logic                  resp_credit_i,
    output l1d_pkg::mem_req_t     mem_req_o,
    input  l1d_pkg::mem_rsp_t     mem_rsp_i
);
    import l1d_pkg::*;

    logic [INDEX_W-1:0]        rd_index;
    line_meta_t                rd_meta;
    logic [XLEN-1:0]           rd_line;
    logic [XLEN-1:0]           fill_line;
    logic [XLEN-1:0]           align_line;
    logic [XLEN-1:0]           ld_data;
    logic [XLEN-1:0]           merged_line;
    logic [XLEN-1:0]           victim_line;
    logic [BYTES_PER_LINE-1:0] store_mask;
    logic [ADDR_W-1:0]         victim_addr;
    logic [ADDR_W-1:0]         fill_addr;
    arr_wr_t                   arr_wr;
    cache_req_t                cur_req;
    logic                      line_sel;
    logic                      mem_start;
    logic                      mem_wb;
    logic                      mem_done;

    // refilled line replaces the array read during fill
    assign align_line = line_sel ? fill_line : rd_line;

    l1d_ctrl ctrl_i (
        .clk           (clk),
        .rstn          (rstn),
        .req_valid_i   (req_valid_i),
        .req_i         (req_i),
        .resp_credit_i (resp_credit_i),
        .req_ready_o   (req_ready_o),
        .resp_valid_o  (resp_valid_o),
        .resp_o        (resp_o),
        .rd_index_o    (rd_index),
        .rd_meta_i     (rd_meta),
        .rd_line_i     (rd_line),
        .arr_wr_o      (arr_wr),
        .cur_req_o     (cur_req),
        .line_sel_o    (line_sel),
        .ld_data_i     (ld_data),
        .merged_line_i (merged_line),
        .store_mask_i  (store_mask),
        .mem_start_o   (mem_start),
        .mem_wb_o      (mem_wb),
        .victim_addr_o (victim_addr),
        .fill_addr_o   (fill_addr),
        .victim_line_o (victim_line),
        .mem_done_i    (mem_done),
        .fill_line_i   (fill_line)
    );

    l1d_line_store store_i (
        .clk        (clk),
        .rstn       (rstn),
        .rd_index_i (rd_index),
        .wr_i       (arr_wr),
        .rd_meta_o  (rd_meta),
        .rd_line_o  (rd_line)
    );

    l1d_align align_i (
        .req_i         (cur_req),
        .line_i        (align_line),
        .ld_data_o     (ld_data),
        .merged_line_o (merged_line),
        .store_mask_o  (store_mask)
    );

    l1d_mem_port mem_port_i (
        .clk           (clk),
        .rstn          (rstn),
        .start_i       (mem_start),
        .wb_i          (mem_wb),
        .victim_addr_i (victim_addr),
        .fill_addr_i   (fill_addr),
        .victim_line_i (victim_line),
        .mem_req_o     (mem_req_o),
        .mem_rsp_i     (mem_rsp_i),
        .done_o        (mem_done),
        .fill_line_o   (fill_line)
    );

endmodule

// File: verilog/l1d_ctrl.sv
`timescale 1ns/1ps

module l1d_ctrl (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic                                req_valid_i,
    input  l1d_pkg::cache_req_t                 req_i,
    input  logic                                resp_credit_i,
    output logic                                req_ready_o,
    output logic                                resp_valid_o,
    output l1d_pkg::cache_resp_t                resp_o,
    output logic [l1d_pkg::INDEX_W-1:0]         rd_index_o,
    input  l1d_pkg::line_meta_t                 rd_meta_i,
    input  logic [l1d_pkg::XLEN-1:0]            rd_line_i,
    output l1d_pkg::arr_wr_t                    arr_wr_o,
    output l1d_pkg::cache_req_t                 cur_req_o,
    output logic                                line_sel_o,
    input  logic [l1d_pkg::XLEN-1:0]            ld_data_i,
    input  logic [l1d_pkg::XLEN-1:0]            merged_line_i,
    input  logic [l1d_pkg::BYTES_PER_LINE-1:0]  store_mask_i,
    output logic                                mem_start_o,
    output logic                                mem_wb_o,
    output logic [l1d_pkg::ADDR_W-1:0]          victim_addr_o,
    output logic [l1d_pkg::ADDR_W-1:0]          fill_addr_o,
    output logic [l1d_pkg::XLEN-1:0]            victim_line_o,
    input  logic                                mem_done_i,
    input  logic [l1d_pkg::XLEN-1:0]            fill_line_i
);
    import l1d_pkg::*;

    cache_state_e          state_q;
    cache_state_e          state_d;
    cache_req_t            req_q;
    logic [CREDIT_W-1:0]   credit_q;
    logic [TAG_W-1:0]      req_tag;
    logic [INDEX_W-1:0]    req_index;
    logic                  is_store;
    logic                  hit;
    logic                  in_lookup;
    logic                  in_fill;

    assign req_tag   = req_q.addr[ADDR_W-1 -: TAG_W];
    assign req_index = req_q.addr[OFFSET_W +: INDEX_W];
    assign is_store  = req_q.op == MEM_STORE;
    assign hit       = rd_meta_i.valid && (rd_meta_i.tag == req_tag);
    assign in_lookup = state_q == ST_LOOKUP;
    assign in_fill   = state_q == ST_FILL;

    assign req_ready_o = (state_q == ST_IDLE) && (credit_q != '0);
    // array read starts while the request is still on the bus
    assign rd_index_o  = (state_q == ST_IDLE) ? req_i.addr[OFFSET_W +: INDEX_W] : req_index;
    assign cur_req_o   = req_q;
    assign line_sel_o  = in_fill;

    ////////////////////
    // state machine

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:   if (req_valid_i && req_ready_o) state_d = ST_LOOKUP;
            ST_LOOKUP: begin
                if (hit) begin
                    state_d = ST_IDLE;
                end else begin
                    state_d = mem_wb_o ? ST_WB_LO : ST_RF_LO;
                end
            end
            // beats are counted in the memory port
            ST_WB_LO, ST_WB_HI, ST_RF_LO, ST_RF_HI: if (mem_done_i) state_d = ST_FILL;
            default:   state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rstn) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid_i && req_ready_o) begin
            req_q <= req_i;
        end
    end

    ////////////////////
    // miss handling

    assign mem_start_o   = in_lookup && !hit;
    assign mem_wb_o      = rd_meta_i.valid && rd_meta_i.dirty;
    assign victim_addr_o = {rd_meta_i.tag, req_index, {OFFSET_W{1'b0}}};
    assign fill_addr_o   = {req_tag, req_index, {OFFSET_W{1'b0}}};
    assign victim_line_o = rd_line_i;

    // store hit writes its lanes, fill writes the whole line
    always_comb begin
        arr_wr_o.en         = (in_lookup && hit && is_store) || in_fill;
        arr_wr_o.index      = req_index;
        arr_wr_o.meta.valid = 1'b1;
        arr_wr_o.meta.dirty = is_store;
        arr_wr_o.meta.tag   = req_tag;
        arr_wr_o.line       = merged_line_i;
        arr_wr_o.byte_mask  = in_fill ? '1 : store_mask_i;
    end

    ////////////////////
    // response and credits

    assign resp_valid_o   = !is_store && ((in_lookup && hit) || in_fill);
    assign resp_o.ld_data = ld_data_i;
    assign resp_o.rob_idx = req_q.rob_idx;

    always_ff @(posedge clk) begin
        if (rstn) begin
            credit_q <= CREDIT_W'(RESP_CREDITS);
        end else begin
            credit_q <= credit_q - CREDIT_W'(resp_valid_o) + CREDIT_W'(resp_credit_i);
        end
    end

    credit_bound_a: assert property (@(posedge clk) disable iff (rstn)
        credit_q <= CREDIT_W'(RESP_CREDITS));

    // a response must always find a credit left by the accept
    resp_credit_a: assert property (@(posedge clk) disable iff (rstn)
        $rose(resp_valid_o) |-> credit_q != '0);

endmodule

// File: verilog/l1d_line_store.sv
`timescale 1ns/1ps

module l1d_line_store (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic [l1d_pkg::INDEX_W-1:0]  rd_index_i,
    input  l1d_pkg::arr_wr_t             wr_i,
    output l1d_pkg::line_meta_t          rd_meta_o,
    output logic [l1d_pkg::XLEN-1:0]     rd_line_o
);
    import l1d_pkg::*;

    logic [LINES-1:0]   valid_q;
    logic [LINES-1:0]   dirty_q;
    logic [TAG_W-1:0]   tag_mem  [LINES];
    logic [XLEN-1:0]    data_mem [LINES];

    always_ff @(posedge clk) begin
        if (rstn) begin
            valid_q <= '0;
        end else if (wr_i.en) begin
            valid_q[wr_i.index] <= wr_i.meta.valid;
        end
    end

    // tag and dirty follow every line write
    always_ff @(posedge clk) begin
        if (wr_i.en) begin
            dirty_q[wr_i.index] <= wr_i.meta.dirty;
            tag_mem[wr_i.index] <= wr_i.meta.tag;
        end
    end

    // per byte lane
    always_ff @(posedge clk) begin
        if (wr_i.en) begin
            for (int b = 0; b < BYTES_PER_LINE; b++) begin
                if (wr_i.byte_mask[b]) begin
                    data_mem[wr_i.index][8*b +: 8] <= wr_i.line[8*b +: 8];
                end
            end
        end
    end

    // registered read returns old contents on a same-cycle write
    always_ff @(posedge clk) begin
        rd_meta_o.valid <= valid_q[rd_index_i];
        rd_meta_o.dirty <= dirty_q[rd_index_i];
        rd_meta_o.tag   <= tag_mem[rd_index_i];
        rd_line_o       <= data_mem[rd_index_i];
    end

    wr_index_known_a: assert property (@(posedge clk) disable iff (rstn)
        wr_i.en |-> !$isunknown(wr_i.index));

endmodule

// File: verilog/l1d_mem_port.sv
`timescale 1ns/1ps

module l1d_mem_port (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         start_i,
    input  logic                         wb_i,
    input  logic [l1d_pkg::ADDR_W-1:0]   victim_addr_i,
    input  logic [l1d_pkg::ADDR_W-1:0]   fill_addr_i,
    input  logic [l1d_pkg::XLEN-1:0]     victim_line_i,
    output l1d_pkg::mem_req_t            mem_req_o,
    input  l1d_pkg::mem_rsp_t            mem_rsp_i,
    output logic                         done_o,
    output logic [l1d_pkg::XLEN-1:0]     fill_line_o
);
    import l1d_pkg::*;

    logic               busy_q;
    cache_state_e       beat_q;
    logic [MEM_W-1:0]   fill_lo_q;
    logic [MEM_W-1:0]   fill_hi_q;
    logic               beat_done;
    logic               wb_beat;
    logic               hi_beat;
    logic [ADDR_W-1:0]  base;

    assign beat_done = busy_q && mem_rsp_i.ack;
    assign wb_beat   = (beat_q == ST_WB_LO) || (beat_q == ST_WB_HI);
    assign hi_beat   = (beat_q == ST_WB_HI) || (beat_q == ST_RF_HI);
    assign base      = wb_beat ? victim_addr_i : fill_addr_i;

    // write-back beats first, then refill
    always_ff @(posedge clk) begin
        if (rstn) begin
            busy_q <= 1'b0;
            beat_q <= ST_RF_LO;
        end else if (start_i) begin
            busy_q <= 1'b1;
            beat_q <= wb_i ? ST_WB_LO : ST_RF_LO;
        end else if (beat_done) begin
            case (beat_q)
                ST_WB_LO: beat_q <= ST_WB_HI;
                ST_WB_HI: beat_q <= ST_RF_LO;
                ST_RF_LO: beat_q <= ST_RF_HI;
                default:  busy_q <= 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (beat_done && beat_q == ST_RF_LO) begin
            fill_lo_q <= mem_rsp_i.rdata;
        end
        if (beat_done && beat_q == ST_RF_HI) begin
            fill_hi_q <= mem_rsp_i.rdata;
        end
    end

    assign fill_line_o = {fill_hi_q, fill_lo_q};
    // high word lands at the same edge the controller moves to fill
    assign done_o      = beat_done && (beat_q == ST_RF_HI);

    assign mem_req_o.cyc = busy_q;
    assign mem_req_o.we  = busy_q && wb_beat;
    assign mem_req_o.adr = {base[ADDR_W-1:OFFSET_W], hi_beat, 2'b00};
    assign mem_req_o.dat = !wb_beat ? '0 :
                           hi_beat  ? victim_line_i[XLEN-1:MEM_W] : victim_line_i[MEM_W-1:0];

    // victim and fill addresses come from the controller and must hold
    bus_stable_a: assert property (@(posedge clk) disable iff (rstn)
        mem_req_o.cyc && !mem_rsp_i.ack |=>
            mem_req_o.cyc && $stable(mem_req_o.adr) && $stable(mem_req_o.we));

endmodule

// File: verilog/l1d_pkg.sv
package l1d_pkg;

    localparam int XLEN           = 64;
    localparam int ADDR_W         = 32;
    localparam int MEM_W          = 32;
    localparam int OFFSET_W       = 3;
    localparam int INDEX_W        = 8;
    localparam int TAG_W          = 21;
    localparam int LINES          = 256;
    localparam int BYTES_PER_LINE = 8;
    localparam int ROB_IDX_W      = 4;
    // responses the consumer can hold
    localparam int RESP_CREDITS   = 2;
    localparam int CREDIT_W       = 2;

    typedef enum logic {
        MEM_LOAD,
        MEM_STORE
    } mem_op_e;

    // bit 2 set means zero extension
    typedef enum logic [2:0] {
        SZ_B  = 3'd0,
        SZ_H  = 3'd1,
        SZ_W  = 3'd2,
        SZ_D  = 3'd3,
        SZ_BU = 3'd4,
        SZ_HU = 3'd5,
        SZ_WU = 3'd6
    } access_size_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WB_LO,
        ST_WB_HI,
        ST_RF_LO,
        ST_RF_HI,
        ST_FILL
    } cache_state_e;

    typedef struct packed {
        mem_op_e                op;
        access_size_e           size;
        logic [ADDR_W-1:0]      addr;
        logic [XLEN-1:0]        wdata;
        logic [ROB_IDX_W-1:0]   rob_idx;
    } cache_req_t;

    typedef struct packed {
        logic [XLEN-1:0]        ld_data;
        logic [ROB_IDX_W-1:0]   rob_idx;
    } cache_resp_t;

    typedef struct packed {
        logic                   valid;
        logic                   dirty;
        logic [TAG_W-1:0]       tag;
    } line_meta_t;

    typedef struct packed {
        logic                       en;
        logic [INDEX_W-1:0]         index;
        line_meta_t                 meta;
        logic [XLEN-1:0]            line;
        logic [BYTES_PER_LINE-1:0]  byte_mask;
    } arr_wr_t;

    typedef struct packed {
        logic                   cyc;
        logic                   we;
        logic [ADDR_W-1:0]      adr;
        logic [MEM_W-1:0]       dat;
    } mem_req_t;

    typedef struct packed {
        logic                   ack;
        logic [MEM_W-1:0]       rdata;
    } mem_rsp_t;

endpackage
